// ==== src/fifo_cfg.svh ====
`ifndef FIFO_CFG_SVH
`define FIFO_CFG_SVH

// ---------------------------------------------------------------------
// Build-time configuration of the flop FIFO
// ---------------------------------------------------------------------

// Total number of entries the buffer accepts, must be at least 2
`define FIFO_DEPTH 8

// Bits carried by each entry
`define FIFO_WIDTH 16

// Set to 1 so that a push into an empty buffer skips the RAM
`define FIFO_BYPASS 1

// Set to 1 to drive pop_valid and pop_data from a forward register
// With 0 the stage signals reach the pop ports combinationally
`define FIFO_REG_POP 1

`endif

// ==== src/fifo_ctrl_1r1w.sv ====
`timescale 1ns/10ps
`include "fifo_cfg.svh"

module fifo_ctrl_1r1w import fifo_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   push_valid,
  input  word_t  push_data,
  output logic   push_ready,
  input  logic   stage_ready,
  output logic   stage_valid,
  output word_t  stage_data,
  input  logic   pop_valid,
  input  logic   pop_ready,
  output logic   ram_wr_en,
  output addr_t  ram_wr_addr,
  output word_t  ram_wr_data,
  output addr_t  ram_rd_addr,
  input  word_t  ram_rd_data,
  output logic   full,
  output logic   empty,
  output count_t items,
  output count_t slots
);

  localparam bit bypass_en = (`FIFO_BYPASS != 0);

  // Pointers into the flop RAM, both wrap at FIFO_DEPTH-1
  addr_t  wr_ptr;
  addr_t  rd_ptr;
  // Entries currently stored in the RAM, not yet handed to the stage side
  count_t ram_items;

  logic ram_empty;
  logic push_xfer;
  logic stage_xfer;
  logic pop_xfer;
  logic bypass;
  logic ram_rd_en;

  // Next pointer value with wrap for depths that are not a power of two
  function automatic addr_t ptr_next(input addr_t ptr);
    addr_t nxt;
    if (ptr == addr_t'(`FIFO_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + addr_t'(1);
    end
    return nxt;
  endfunction

  // ---------------------------------------------------------------------
  // Handshakes
  // ---------------------------------------------------------------------

  // Push is accepted whenever the total occupancy is below the depth
  assign push_ready = ~full;
  assign push_xfer  = push_valid & push_ready;

  // The entry leaves the FIFO when the sink takes it at the pop ports
  assign pop_xfer = pop_valid & pop_ready;

  assign ram_empty = (ram_items == '0);

  // A push skips storage only when the RAM holds nothing and the stage
  // side can take the word in this same cycle
  assign bypass = bypass_en & ram_empty & stage_ready;

  // The head of the RAM has priority, otherwise the live push is offered
  // when bypass is enabled
  always_comb begin
    if (!ram_empty) begin
      stage_valid = 1'b1;
      stage_data  = ram_rd_data;
    end else begin
      stage_valid = bypass_en & push_valid & push_ready;
      stage_data  = push_data;
    end
  end

  assign stage_xfer = stage_valid & stage_ready;

  // A stage transfer only consumes a RAM entry when the RAM was the source
  assign ram_rd_en = stage_xfer & ~ram_empty;

  // ---------------------------------------------------------------------
  // RAM port driving
  // ---------------------------------------------------------------------

  assign ram_wr_en   = push_xfer & ~bypass;
  assign ram_wr_addr = wr_ptr;
  assign ram_wr_data = push_data;
  assign ram_rd_addr = rd_ptr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (ram_wr_en) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (ram_rd_en) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
    end
  end

  // RAM occupancy, a simultaneous write and read leaves it as it is
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ram_items <= '0;
    end else begin
      case ({ram_wr_en, ram_rd_en})
        2'b10:   ram_items <= ram_items + count_t'(1);
        2'b01:   ram_items <= ram_items - count_t'(1);
        default: ram_items <= ram_items;
      endcase
    end
  end

  // ---------------------------------------------------------------------
  // Occupancy and flags
  // ---------------------------------------------------------------------

  // Counts an entry from push until the sink pops it, so a word parked
  // in the pop register is still included
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      items <= '0;
    end else begin
      case ({push_xfer, pop_xfer})
        2'b10:   items <= items + count_t'(1);
        2'b01:   items <= items - count_t'(1);
        default: items <= items;
      endcase
    end
  end

  // Flags follow the registered count, so they move one edge after the
  // transfer that changed it
  assign full  = (items == count_t'(`FIFO_DEPTH));
  assign empty = (items == '0);
  assign slots = count_t'(`FIFO_DEPTH) - items;

endmodule

// ==== src/fifo_flops.sv ====
`timescale 1ns/10ps
`include "fifo_cfg.svh"

module fifo_flops import fifo_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   push_valid,
  input  word_t  push_data,
  output logic   push_ready,
  input  logic   pop_ready,
  output logic   pop_valid,
  output word_t  pop_data,
  output logic   full,
  output logic   empty,
  output count_t items,
  output count_t slots
);

  // Stage link between the control block and the pop side
  logic  stage_valid;
  logic  stage_ready;
  word_t stage_data;

  // RAM ports
  logic  ram_wr_en;
  addr_t ram_wr_addr;
  word_t ram_wr_data;
  addr_t ram_rd_addr;
  word_t ram_rd_data;

  // ---------------------------------------------------------------------
  // Control
  // ---------------------------------------------------------------------

  fifo_ctrl_1r1w u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_valid  (push_valid),
    .push_data   (push_data),
    .push_ready  (push_ready),
    .stage_ready (stage_ready),
    .stage_valid (stage_valid),
    .stage_data  (stage_data),
    .pop_valid   (pop_valid),
    .pop_ready   (pop_ready),
    .ram_wr_en   (ram_wr_en),
    .ram_wr_addr (ram_wr_addr),
    .ram_wr_data (ram_wr_data),
    .ram_rd_addr (ram_rd_addr),
    .ram_rd_data (ram_rd_data),
    .full        (full),
    .empty       (empty),
    .items       (items),
    .slots       (slots)
  );

  // ---------------------------------------------------------------------
  // Storage
  // ---------------------------------------------------------------------

  fifo_ram_flops u_ram (
    .clk     (clk),
    .wr_en   (ram_wr_en),
    .wr_addr (ram_wr_addr),
    .wr_data (ram_wr_data),
    .rd_addr (ram_rd_addr),
    .rd_data (ram_rd_data)
  );

  // ---------------------------------------------------------------------
  // Pop side
  // ---------------------------------------------------------------------

  // Registered outputs cost one cycle of cut-through latency but cut the
  // combinational path from the push ports to the pop ports
  if (`FIFO_REG_POP != 0) begin : g_pop_reg
    fifo_pop_reg u_pop_reg (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (stage_valid),
      .in_data   (stage_data),
      .in_ready  (stage_ready),
      .out_valid (pop_valid),
      .out_data  (pop_data),
      .out_ready (pop_ready)
    );
  end else begin : g_pop_direct
    assign pop_valid   = stage_valid;
    assign pop_data    = stage_data;
    assign stage_ready = pop_ready;
  end

endmodule

// ==== src/fifo_pkg.sv ====
`include "fifo_cfg.svh"

package fifo_pkg;

  // ---------------------------------------------------------------------
  // Types shared by the control block, the RAM and the pop register
  // ---------------------------------------------------------------------

  // One buffer entry as it travels from push to pop
  typedef logic [`FIFO_WIDTH-1:0] word_t;

  // Index into the flop RAM
  // The depth is at least 2, so the index is never narrower than 1 bit
  typedef logic [$clog2(`FIFO_DEPTH)-1:0] addr_t;

  // Occupancy and free-slot counts need to reach FIFO_DEPTH itself
  typedef logic [$clog2(`FIFO_DEPTH+1)-1:0] count_t;

endpackage

// ==== src/fifo_pop_reg.sv ====
`timescale 1ns/10ps
`include "fifo_cfg.svh"

module fifo_pop_reg import fifo_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid,
  input  word_t in_data,
  output logic  in_ready,
  output logic  out_valid,
  output word_t out_data,
  input  logic  out_ready
);

  logic in_xfer;

  // ---------------------------------------------------------------------
  // Forward flow register
  // ---------------------------------------------------------------------

  // Room is available when the slot is empty, or when the sink is taking
  // the current word this cycle
  // The second case keeps the throughput at one word per cycle
  assign in_ready = ~out_valid | out_ready;
  assign in_xfer  = in_valid & in_ready;

  // Valid bit is the only control state here
  // It is reloaded whenever the slot frees up, so it drops after a pop
  // with no new word behind it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // Payload is only loaded on an accepted word and holds otherwise,
  // which keeps out_data stable under back-pressure
  always_ff @(posedge clk) begin
    if (in_xfer) begin
      out_data <= in_data;
    end
  end

endmodule

// ==== src/fifo_ram_flops.sv ====
`timescale 1ns/10ps
`include "fifo_cfg.svh"

module fifo_ram_flops import fifo_pkg::*; (
  input  logic  clk,
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  word_t wr_data,
  input  addr_t rd_addr,
  output word_t rd_data
);

  // ---------------------------------------------------------------------
  // Storage array
  // ---------------------------------------------------------------------

  // One flop word per buffer entry
  word_t mem [`FIFO_DEPTH];

  // Write port
  // The addressed word takes the new data on the rising edge
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ---------------------------------------------------------------------
  // Read port
  // ---------------------------------------------------------------------

  // Combinational mux over all entries, so the read returns the word in
  // the same cycle the address is presented
  // An index beyond the depth reads as zero, which only matters for
  // depths that are not a power of two
  always_comb begin
    rd_data = '0;
    for (int i = 0; i < `FIFO_DEPTH; i++) begin
      if (rd_addr == addr_t'(i)) begin
        rd_data = mem[i];
      end
    end
  end

endmodule

// ==== testbench/fifo_flops_tb.sv ====
`timescale 1ns/10ps
`include "fifo_cfg.svh"

module fifo_flops_tb import fifo_pkg::*; ();

  localparam int depth    = `FIFO_DEPTH;
  localparam int num_rows = 6;
  localparam int m_off    = 0;
  localparam int m_on     = 1;
  localparam int m_rnd    = 2;
  // Cycles from a push into an empty buffer until pop_valid is seen
  localparam int exp_lat  = ((`FIFO_BYPASS != 0) ? 0 : 1) + ((`FIFO_REG_POP != 0) ? 1 : 0);

  logic   clk;
  logic   rst_n;
  logic   push_valid;
  word_t  push_data;
  logic   push_ready;
  logic   pop_ready;
  logic   pop_valid;
  word_t  pop_data;
  logic   full;
  logic   empty;
  count_t items;
  count_t slots;

  // ---------------------------------------------------------------------
  // Stimulus table with one row per test phase
  // ---------------------------------------------------------------------

  // Fill, drain, random traffic, drain, random fill, final drain
  // Drain rows get a few spare cycles for a push still held from the row before
  int row_cycles [num_rows] = '{depth + 3, depth + 6, 300, depth + 6, 60, depth + 6};
  int row_push   [num_rows] = '{m_on, m_off, m_rnd, m_off, m_rnd, m_off};
  int row_pop    [num_rows] = '{m_off, m_on, m_rnd, m_on, m_off, m_on};
  // Rows with 0 here have no fixed end state
  bit row_chk    [num_rows] = '{1, 1, 0, 1, 0, 1};
  bit row_full   [num_rows] = '{1, 0, 0, 0, 0, 0};
  bit row_empty  [num_rows] = '{0, 1, 0, 1, 0, 1};
  int row_items  [num_rows] = '{depth, 0, 0, 0, 0, 0};

  // Reference model of the buffer contents in push order
  word_t ref_q [$];
  int    errors;
  int    checks;
  logic  last_valid;
  logic  last_ready;
  word_t last_data;
  bit    push_hold;
  logic  seen_valid;
  word_t seen_data;

  fifo_flops UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_data  (push_data),
    .push_ready (push_ready),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .full       (full),
    .empty      (empty),
    .items      (items),
    .slots      (slots)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ---------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------

  task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, msg, actual, expected);
    end
  endtask

  // Turns a table mode into the level for one cycle
  function automatic bit mode_value(input int mode);
    bit v;
    case (mode)
      m_on:    v = 1'b1;
      m_rnd:   v = $urandom % 2;
      default: v = 1'b0;
    endcase
    return v;
  endfunction

  // Runs one clock cycle that starts and ends at a falling edge
  // A push that was not taken keeps its valid and its data
  task automatic run_cycle(input bit pv, input bit pr);
    bit push_xfer;
    bit pop_xfer;
    if (push_hold) begin
      pv = 1'b1;
    end else begin
      push_data = word_t'($urandom);
    end
    push_valid = pv;
    pop_ready  = pr;
    #1;
    push_xfer  = push_valid & push_ready;
    pop_xfer   = pop_valid & pop_ready;
    seen_valid = pop_valid;
    seen_data  = pop_data;
    if (full) begin
      compare(push_xfer, 1'b0, "push accepted while full");
    end
    // The sink stalled last cycle, so the offered word must not move
    if (last_valid && !last_ready) begin
      compare(pop_valid, 1'b1, "pop_valid dropped under back-pressure");
      compare(pop_data, last_data, "pop_data changed under back-pressure");
    end
    // Push first, since a bypassed word may leave in the cycle it arrives
    if (push_xfer) begin
      ref_q.push_back(push_data);
    end
    if (pop_xfer) begin
      if (ref_q.size() == 0) begin
        errors++;
        $display("Pop transfer at %0t ns with nothing left in the reference queue", $time);
      end else begin
        compare(pop_data, ref_q.pop_front(), "pop_data out of push order");
      end
    end
    push_hold  = push_valid & ~push_xfer;
    last_valid = pop_valid;
    last_ready = pop_ready;
    last_data  = pop_data;
    @(posedge clk);
    @(negedge clk);
    compare(items, ref_q.size(), "items differs from reference queue length");
  endtask

  // ---------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------

  initial begin
    int    row_errs;
    int    lat;
    word_t ct_word;
    void'($urandom(71760));
    errors     = 0;
    checks     = 0;
    rst_n      = 1'b0;
    push_valid = 1'b0;
    push_data  = '0;
    pop_ready  = 1'b0;
    last_valid = 1'b0;
    last_ready = 1'b0;
    last_data  = '0;
    push_hold  = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    compare(push_ready, 1'b1, "push_ready after reset");
    compare(pop_valid, 1'b0, "pop_valid after reset");
    compare(empty, 1'b1, "empty after reset");
    compare(full, 1'b0, "full after reset");
    compare(items, 0, "items after reset");
    compare(slots, depth, "slots after reset");
    $display("Reset state: %0d errors", errors);

    for (int r = 0; r < num_rows; r++) begin
      row_errs = errors;
      repeat (row_cycles[r]) run_cycle(mode_value(row_push[r]), mode_value(row_pop[r]));
      if (row_chk[r]) begin
        compare(full, row_full[r], "full at end of row");
        compare(empty, row_empty[r], "empty at end of row");
        compare(items, row_items[r], "items at end of row");
        compare(slots, depth - row_items[r], "slots at end of row");
        compare(push_ready, !row_full[r], "push_ready at end of row");
      end else begin
        compare(slots, depth - ref_q.size(), "slots against reference queue");
      end
      $display("Row %0d: %0d cycles, %0d errors", r, row_cycles[r], errors - row_errs);
    end

    // Cut-through of a single word into the empty buffer
    row_errs = errors;
    compare(empty, 1'b1, "buffer not empty before cut-through");
    run_cycle(1'b1, 1'b0);
    ct_word = push_data;
    lat = 0;
    while (!seen_valid && lat < 8) begin
      run_cycle(1'b0, 1'b0);
      lat++;
    end
    compare(lat, exp_lat, "cut-through latency in cycles");
    compare(seen_data, ct_word, "cut-through word");
    repeat (4) run_cycle(1'b0, 1'b1);
    compare(empty, 1'b1, "empty after cut-through drain");
    $display("Cut-through: latency %0d, %0d errors", lat, errors - row_errs);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog sized from the table plus reset, cut-through and a margin
  initial begin
    int total;
    total = 60;
    for (int i = 0; i < num_rows; i++) begin
      total += row_cycles[i];
    end
    #(40 * total);
    $display("Simulation timed out before the sequence finished");
    $display("tests failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+src
src/fifo_pkg.sv
src/fifo_ram_flops.sv
src/fifo_pop_reg.sv
src/fifo_ctrl_1r1w.sv
src/fifo_flops.sv
testbench/fifo_flops_tb.sv
